// ==== kabuki_defs.svh ====
// Kabuki fetch unit sizing.
// Queue depth, credit pool sizes and key length shared by the RTL blocks.

`ifndef KABUKI_DEFS_SVH
`define KABUKI_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// entries in the ring, also the request credits upstream holds after reset.
`define KABUKI_QUEUE_DEPTH 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// credit pools
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define KABUKI_ROM_CREDITS 2 // rom request slots after reset.
`define KABUKI_OUT_CREDITS 4 // consumer beat slots after reset.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cipher keys
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define KABUKI_KEY_BYTES 11 // two swap keys, address key, xor key.

`endif

// ==== kabuki_bus_pkg.sv ====
// Kabuki fetch bus types.
// Address and data widths, request and response beats, fetch FSM states.

`default_nettype none

package kabuki_bus_pkg;

    typedef logic [15:0] addr_t; // z80 address.
    typedef logic [7:0]  byte_t; // rom or plain data byte.

    // cpu read request, m1 high marks an opcode fetch.
    typedef struct packed {
        addr_t addr;
        logic  m1;
    } fetch_req_t;

    // decrypted beat handed to the consumer.
    typedef struct packed {
        addr_t addr;
        byte_t data;
    } fetch_rsp_t;

    // fetch FSM states.
    typedef enum logic [1:0] {
        st_load  = 2'd0, // collecting key bytes, no fetches.
        st_run   = 2'd1, // normal fetching.
        st_drain = 2'd2  // finishing queued fetches before a reload.
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== kabuki_key_pkg.sv ====
// Kabuki key types.
// Programming byte and the 88-bit key set split into its fields.

`default_nettype none

package kabuki_key_pkg;

    typedef logic [7:0]  key_byte_t;  // one programming byte.
    typedef logic [15:0] swap_half_t; // four 3-bit pair selectors.

    // [0] is the low half, [1] the high half.
    typedef swap_half_t [1:0] swap_key_t;

    typedef logic [15:0] addr_key_t; // added to the fetch address.
    typedef key_byte_t   xor_key_t;  // xor applied mid-cipher.

    // first programmed byte lands in the top of swap_key1.
    typedef struct packed {
        swap_key_t swap_key1;
        swap_key_t swap_key2;
        addr_key_t addr_key;
        xor_key_t  xor_key;
    } key_set_t;

endpackage

`default_nettype wire

// ==== key_store.sv ====
// Kabuki key store.
// Shifts programming bytes into the key set and flags a complete load.

`timescale 1ns/1ps
`default_nettype none

`include "kabuki_defs.svh"

module key_store import kabuki_key_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      load_en,
    input  key_byte_t prog_data,
    input  logic      prog_we,
    output key_set_t  keys,
    output logic      keys_complete
);

    localparam int CNT_W  = $clog2(`KABUKI_KEY_BYTES + 1);
    localparam int KEEP_W = $bits(key_set_t) - $bits(key_byte_t);

    logic [CNT_W-1:0] byte_cnt;  // bytes taken since the last load started.
    logic             load_en_q; // for the falling edge of load_en.
    logic             take;

    assign take = load_en && prog_we;

    // new byte enters at the bottom, oldest moves toward swap_key1.
    always_ff @(posedge clk) begin
        if (take) begin
            keys <= key_set_t'({keys[KEEP_W-1:0], prog_data});
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt  <= '0;
            load_en_q <= 1'b0;
        end else begin
            load_en_q <= load_en;
            if (load_en_q && !load_en) begin
                byte_cnt <= '0; // leaving load, next load starts over.
            end else if (take && !keys_complete) begin
                byte_cnt <= byte_cnt + 1'b1; // saturates at the key length.
            end
        end
    end

    assign keys_complete = (byte_cnt == CNT_W'(`KABUKI_KEY_BYTES));

    a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        byte_cnt <= CNT_W'(`KABUKI_KEY_BYTES));

endmodule

`default_nettype wire

// ==== credit_counter.sv ====
// Credit pool counter.
// Starts full at INIT, take spends a credit, give returns one.

`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
    parameter int INIT  = 2,
    parameter int WIDTH = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic take,
    input  logic give,
    output logic avail
);

    logic [WIDTH-1:0] count; // credits currently held.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= WIDTH'(INIT);
        end else begin
            case ({take, give})
                2'b10:   count <= count - 1'b1; // spent.
                2'b01:   count <= count + 1'b1; // returned.
                default: count <= count;        // both or neither.
            endcase
        end
    end

    assign avail = (count != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pool checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // spending with an empty pool means the issuer ignored avail.
    a_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        take |-> count != '0);

    // the far side returned more credits than it was ever given.
    a_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (give && !take) |-> count < WIDTH'(INIT));

endmodule

`default_nettype wire

// ==== fetch_fsm.sv ====
// Fetch control FSM.
// Sequences key load, normal run and drain, and times each rom request.

`timescale 1ns/1ps
`default_nettype none

module fetch_fsm import kabuki_bus_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic prog_en,
    input  logic keys_complete,
    input  logic issue_pending,
    input  logic queue_empty,
    input  logic rom_credit_avail,
    input  logic out_credit_avail,
    output logic issue,
    output logic load_en
);

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic         can_issue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            st_load: begin
                if (keys_complete && !prog_en) begin
                    state_nxt = st_run; // keys in and programming done.
                end
            end
            st_run: begin
                if (prog_en) begin
                    state_nxt = st_drain; // reload requested.
                end
            end
            st_drain: begin
                if (queue_empty) begin
                    state_nxt = st_load; // every fetch answered.
                end
            end
            default: state_nxt = st_load;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_load;
        end else begin
            state <= state_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // drain keeps issuing entries already queued so the ring can empty.
    // no issue right after an issue, the queue and credits update first.
    assign can_issue = (state == st_run || state == st_drain) && issue_pending &&
                       rom_credit_avail && out_credit_avail && !issue;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue <= 1'b0;
        end else begin
            issue <= can_issue; // registered, drives rom_valid directly.
        end
    end

    assign load_en = (state == st_load); // key bytes only while loading.

endmodule

`default_nettype wire

// ==== fetch_queue.sv ====
// In-order fetch request queue.
// Holds each request from acceptance until its rom byte returns.

`timescale 1ns/1ps
`default_nettype none

`include "kabuki_defs.svh"

module fetch_queue import kabuki_bus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  fetch_req_t push_req,
    input  logic       issue,
    output fetch_req_t issue_req,
    output logic       issue_pending,
    input  logic       retire,
    output fetch_req_t retire_req,
    output logic       empty
);

    localparam int DEPTH = `KABUKI_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    fetch_req_t ring [DEPTH]; // request storage.
    logic [AW:0] wr_ptr;      // extra msb tells full from empty.
    logic [AW:0] iss_ptr;     // next entry to send to the rom.
    logic [AW:0] ret_ptr;     // entry whose byte comes back next.
    logic        full;

    always_ff @(posedge clk) begin
        if (push) begin
            ring[wr_ptr[AW-1:0]] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            iss_ptr <= '0;
            ret_ptr <= '0;
        end else begin
            if (push)   wr_ptr  <= wr_ptr + 1'b1;
            if (issue)  iss_ptr <= iss_ptr + 1'b1;
            if (retire) ret_ptr <= ret_ptr + 1'b1;
        end
    end

    assign issue_req     = ring[iss_ptr[AW-1:0]];
    assign retire_req    = ring[ret_ptr[AW-1:0]];
    assign issue_pending = (wr_ptr != iss_ptr);          // accepted, not yet issued.
    assign empty         = (wr_ptr == ret_ptr);          // nothing stored at all.
    assign full          = ((wr_ptr - ret_ptr) == (AW+1)'(DEPTH));

    a_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> !full);
    a_issue_none: assert property (@(posedge clk) disable iff (!arst_n)
        issue |-> issue_pending);
    a_retire_empty: assert property (@(posedge clk) disable iff (!arst_n)
        retire |-> !empty);

endmodule

`default_nettype wire

// ==== kabuki_decrypt.sv ====
// Kabuki decryption stage.
// Unscrambles a rom byte with the key set and its address hit, registered.

`timescale 1ns/1ps
`default_nettype none

module kabuki_decrypt import kabuki_bus_pkg::*, kabuki_key_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  key_set_t   keys,
    input  fetch_req_t tag,
    input  byte_t      cipher,
    input  logic       cipher_valid,
    output fetch_rsp_t rsp,
    output logic       rsp_valid
);

    addr_t addr_hit; // address mixed with the address key.
    byte_t plain;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cipher primitives
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // each bit pair swaps when its selected hit bit is set.
    // variant 1 takes selector p for pair p, variant 2 takes them reversed.
    function automatic byte_t pair_swap(input byte_t din, input swap_half_t key,
                                        input byte_t hit, input logic reversed);
        byte_t    dout;
        logic [2:0] sel;
        int       k;
        dout = din;
        for (int p = 0; p < 4; p++) begin
            k   = reversed ? 3 - p : p;
            sel = key[4*k +: 3];
            if (hit[sel]) begin
                dout[2*p]   = din[2*p+1];
                dout[2*p+1] = din[2*p];
            end
        end
        return dout;
    endfunction

    function automatic byte_t rol1(input byte_t din);
        return {din[6:0], din[7]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transform
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (tag.m1) begin
            addr_hit = tag.addr + keys.addr_key; // opcode fetch.
        end else begin
            addr_hit = (tag.addr ^ 16'h1fc0) + keys.addr_key + 16'd1; // data fetch.
        end

        plain = pair_swap(cipher, keys.swap_key1[0], addr_hit[7:0], 1'b0);
        plain = rol1(plain);
        plain = pair_swap(plain, keys.swap_key1[1], addr_hit[7:0], 1'b1);
        plain = rol1(plain ^ keys.xor_key);
        plain = pair_swap(plain, keys.swap_key2[0], addr_hit[15:8], 1'b1);
        plain = rol1(plain);
        plain = pair_swap(plain, keys.swap_key2[1], addr_hit[15:8], 1'b0);
    end

    // beat carries the address it was fetched from.
    always_ff @(posedge clk) begin
        if (cipher_valid) begin
            rsp.addr <= tag.addr;
            rsp.data <= plain;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= cipher_valid; // one cycle behind the rom byte.
        end
    end

endmodule

`default_nettype wire

// ==== kabuki_fetch_top.sv ====
// Kabuki decrypting fetch unit.
// Queues cpu reads, issues them to rom under credits, decrypts the replies.

`timescale 1ns/1ps
`default_nettype none

`include "kabuki_defs.svh"

module kabuki_fetch_top import kabuki_bus_pkg::*, kabuki_key_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // cpu requests.
    input  fetch_req_t req,
    input  logic       req_valid,
    output logic       req_credit,
    // rom port.
    output addr_t      rom_addr,
    output logic       rom_valid,
    input  logic       rom_credit,
    input  byte_t      rom_data,
    input  logic       rom_data_valid,
    // plain output beats.
    output fetch_rsp_t rsp,
    output logic       rsp_valid,
    input  logic       rsp_credit,
    // key programming.
    input  logic       prog_en,
    input  key_byte_t  prog_data,
    input  logic       prog_we
);

    logic       issue;          // one rom request this cycle.
    logic       issue_pending;
    logic       queue_empty;
    logic       rom_avail;
    logic       out_avail;
    logic       load_en;
    logic       keys_complete;
    key_set_t   keys;
    fetch_req_t issue_req;
    fetch_req_t retire_req;     // tag of the byte on rom_data.

    fetch_queue i_fetch_queue (
        .clk, .arst_n,
        .push(req_valid), .push_req(req),
        .issue, .issue_req, .issue_pending,
        .retire(rom_data_valid), .retire_req, .empty(queue_empty)
    );

    fetch_fsm i_fetch_fsm (
        .clk, .arst_n, .prog_en, .keys_complete, .issue_pending, .queue_empty,
        .rom_credit_avail(rom_avail), .out_credit_avail(out_avail), .issue, .load_en
    );

    key_store i_key_store (
        .clk, .arst_n, .load_en, .prog_data, .prog_we, .keys, .keys_complete
    );

    // output slot is booked at issue so rom replies never stall.
    credit_counter #(
        .INIT(`KABUKI_ROM_CREDITS), .WIDTH($clog2(`KABUKI_ROM_CREDITS + 1))
    ) i_rom_credits (
        .clk, .arst_n, .take(issue), .give(rom_credit), .avail(rom_avail)
    );

    credit_counter #(
        .INIT(`KABUKI_OUT_CREDITS), .WIDTH($clog2(`KABUKI_OUT_CREDITS + 1))
    ) i_out_credits (
        .clk, .arst_n, .take(issue), .give(rsp_credit), .avail(out_avail)
    );

    kabuki_decrypt i_kabuki_decrypt (
        .clk, .arst_n, .keys, .tag(retire_req),
        .cipher(rom_data), .cipher_valid(rom_data_valid), .rsp, .rsp_valid
    );

    assign rom_addr   = issue_req.addr;
    assign rom_valid  = issue;
    assign req_credit = rsp_valid; // entry retired the cycle before.

endmodule

`default_nettype wire

// ==== tb_kabuki_fetch.sv ====
// Testbench for the kabuki decrypting fetch unit.
// Random cpu reads run against rom and consumer models and a cipher model checks each beat.

`timescale 1ns/1ps
`default_nettype none

`include "kabuki_defs.svh"

module tb_kabuki_fetch
    import kabuki_bus_pkg::*, kabuki_key_pkg::*;
();

    localparam int unsigned SEED = 32'h3ce0_ce1f;
    localparam int NREQ_A     = 150;              // requests before the key reload.
    localparam int NREQ       = 300;              // requests in the whole run.
    localparam int TIMEOUT_NS = NREQ * 2000 * 100; // 2000 cycles per request.

    logic       clk;
    logic       arst_n;
    fetch_req_t req;
    logic       req_valid;
    logic       req_credit;
    addr_t      rom_addr;
    logic       rom_valid;
    logic       rom_credit;
    byte_t      rom_data;
    logic       rom_data_valid;
    fetch_rsp_t rsp;
    logic       rsp_valid;
    logic       rsp_credit;
    logic       prog_en;
    key_byte_t  prog_data;
    logic       prog_we;

    byte_t      rom_mem [65536];                // scrambled program rom.
    key_byte_t  key_bytes [`KABUKI_KEY_BYTES];  // in programming order.
    fetch_req_t sb_q [$];                       // accepted and still waiting for a beat.
    addr_t      rom_q [$];                      // issued and not answered by the rom yet.
    int         up_credits;
    int         sent;
    int         send_limit;
    int         rom_wait;
    int         held;      // beats the consumer still holds.
    int         rom_out;   // rom requests in flight.
    int         out_used;  // output slots booked.
    int         issued;    // head entries of sb_q already sent to the rom.
    bit         send_en;
    bit         fetch_allowed;
    bit         stall;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    kabuki_fetch_top i_kabuki_fetch_top (
        .clk, .arst_n, .req, .req_valid, .req_credit,
        .rom_addr, .rom_valid, .rom_credit, .rom_data, .rom_data_valid,
        .rsp, .rsp_valid, .rsp_credit, .prog_en, .prog_data, .prog_we
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cipher model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic byte_t rotate_left(input byte_t v);
        return {v[6:0], v[7]};
    endfunction

    // pair p swaps when the hit bit picked by its selector nibble is set.
    // high_first hands pair 0 the top nibble instead of the bottom one.
    function automatic byte_t swap_pairs(input byte_t v, input logic [15:0] sel_word,
                                         input byte_t hit, input bit high_first);
        byte_t      r;
        logic [1:0] nib;
        logic [2:0] s;
        r = v;
        for (int p = 0; p < 4; p++) begin
            nib = high_first ? 2'(3 - p) : 2'(p);
            s   = sel_word[nib*4 +: 3];
            if (hit[s]) begin
                r[2*p +: 2] = {v[2*p], v[2*p+1]};
            end
        end
        return r;
    endfunction

    function automatic byte_t expected_plain(input fetch_req_t r, input byte_t cipher);
        logic [31:0] sk1;
        logic [31:0] sk2;
        logic [15:0] ak;
        logic [15:0] sel;
        byte_t       v;
        sk1 = {key_bytes[0], key_bytes[1], key_bytes[2], key_bytes[3]}; // first byte on top.
        sk2 = {key_bytes[4], key_bytes[5], key_bytes[6], key_bytes[7]};
        ak  = {key_bytes[8], key_bytes[9]};
        if (r.m1) begin
            sel = r.addr + ak;
        end else begin
            sel = (r.addr ^ 16'h1fc0) + ak + 16'd1;
        end
        v = swap_pairs(cipher, sk1[15:0], sel[7:0], 1'b0);
        v = rotate_left(v);
        v = swap_pairs(v, sk1[31:16], sel[7:0], 1'b1);
        v = rotate_left(v ^ key_bytes[10]);
        v = swap_pairs(v, sk2[15:0], sel[15:8], 1'b1);
        v = rotate_left(v);
        v = swap_pairs(v, sk2[31:16], sel[15:8], 1'b0);
        return v;
    endfunction

    task automatic fail_now(input string what);
        $display("FAIL %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    // programs a fresh random key set and holds prog_en high until the last byte.
    task automatic load_keys();
        prog_en = 1'b1;
        for (int i = 0; i < `KABUKI_KEY_BYTES; i++) begin
            @(negedge clk);
            key_bytes[i] = key_byte_t'($urandom);
            prog_data    = key_bytes[i];
            prog_we      = 1'b1;
        end
        @(negedge clk);
        prog_we       = 1'b0;
        prog_en       = 1'b0;
        fetch_allowed = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        req_valid = 1'b0;
        if (arst_n && send_en && up_credits > 0 && sent < send_limit) begin
            req.addr  = addr_t'($urandom);
            req.m1    = 1'($urandom); // opcode or data fetch.
            req_valid = 1'b1;
            up_credits--;
            sent++;
            sb_q.push_back(req);
        end
    end

    // rom answers in order and returns one credit with every byte.
    always @(negedge clk) begin
        rom_data_valid = 1'b0;
        rom_credit     = 1'b0;
        if (rom_q.size() > 0) begin
            if (rom_wait > 0) begin
                rom_wait--;
            end else begin
                rom_data       = rom_mem[rom_q.pop_front()];
                rom_data_valid = 1'b1;
                rom_credit     = 1'b1;
                rom_wait       = int'($urandom_range(5, 0));
            end
        end
    end

    always @(negedge clk) begin
        rsp_credit = 1'b0;
        if ($urandom_range(63, 0) == 0) begin
            stall = !stall; // long stretches with no credits back.
        end
        if (held > 0 && !stall && $urandom_range(2, 0) == 0) begin
            rsp_credit = 1'b1;
            held--;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        fetch_req_t exp;
        if (arst_n) begin
            if (rom_valid) begin
                // requests go to the rom in acceptance order.
                assert (issued < sb_q.size())
                    else fail_now("rom request with no accepted request left to issue");
                assert (rom_addr == sb_q[issued].addr)
                    else fail_now($sformatf("rom addr %h, expected %h", rom_addr,
                                            sb_q[issued].addr));
                rom_q.push_back(rom_addr);
                issued++;
                rom_out++;
                out_used++; // slot booked at issue.
            end
            if (rom_data_valid) rom_out--;
            if (rsp_credit)     out_used--;
            if (req_credit)     up_credits++;
            if (rsp_valid)      held++;
            assert (fetch_allowed || !(rom_valid || rsp_valid))
                else fail_now("rom request or beat while no key set is active");
            assert (rom_out <= `KABUKI_ROM_CREDITS)
                else fail_now($sformatf("%0d rom requests in flight", rom_out));
            assert (out_used <= `KABUKI_OUT_CREDITS)
                else fail_now($sformatf("%0d output slots in use", out_used));
            assert (up_credits <= `KABUKI_QUEUE_DEPTH)
                else fail_now("more request credits returned than granted");
            assert (req_credit == rsp_valid)
                else fail_now($sformatf("req_credit %b with rsp_valid %b", req_credit, rsp_valid));
            if (rsp_valid) begin
                assert (sb_q.size() > 0) else fail_now("beat with no request outstanding");
                exp = sb_q.pop_front();
                issued--;
                assert (rsp.addr == exp.addr)
                    else fail_now($sformatf("beat addr %h, expected %h", rsp.addr, exp.addr));
                assert (rsp.data == expected_plain(exp, rom_mem[exp.addr]))
                    else fail_now($sformatf("addr %h m1 %b data %h, expected %h", exp.addr,
                                            exp.m1, rsp.data, expected_plain(exp, rom_mem[exp.addr])));
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int unsigned rnd;
        rnd = $urandom(SEED);
        foreach (rom_mem[a]) rom_mem[a] = byte_t'($urandom);
        arst_n         = 1'b0;
        req            = '0;
        req_valid      = 1'b0;
        rom_data       = '0;
        rom_data_valid = 1'b0;
        rom_credit     = 1'b0;
        rsp_credit     = 1'b0;
        prog_en        = 1'b0;
        prog_data      = '0;
        prog_we        = 1'b0;
        up_credits     = `KABUKI_QUEUE_DEPTH;
        sent           = 0;
        send_limit     = NREQ_A;
        rom_wait       = 0;
        held           = 0;
        rom_out        = 0;
        out_used       = 0;
        issued         = 0;
        send_en        = 1'b0;
        fetch_allowed  = 1'b0;
        stall          = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        // requests pile up while no key is loaded.
        send_en = 1'b1;
        repeat (20) @(negedge clk);
        assert (sb_q.size() == `KABUKI_QUEUE_DEPTH)
            else fail_now("upstream could not fill the queue before the key load");
        load_keys();
        while (sent < NREQ_A) @(negedge clk);

        // reload with fetches still in flight so they finish under the old keys.
        send_en = 1'b0;
        @(negedge clk);
        prog_en = 1'b1;
        while (sb_q.size() > 0) @(negedge clk);
        fetch_allowed = 1'b0; // no rom request until the new keys are in.
        repeat (4) @(negedge clk);
        load_keys();
        send_limit = NREQ;
        send_en    = 1'b1;
        while (sent < NREQ || sb_q.size() > 0) @(negedge clk);
        repeat (10) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== kabuki_fetch_top.f ====
+incdir+.
kabuki_bus_pkg.sv
kabuki_key_pkg.sv
key_store.sv
credit_counter.sv
fetch_fsm.sv
fetch_queue.sv
kabuki_decrypt.sv
kabuki_fetch_top.sv
tb_kabuki_fetch.sv

// ==== Makefile ====
TB = tb_kabuki_fetch

all: run

build:
	verilator --binary --timing --assert -f kabuki_fetch_top.f --top-module $(TB) -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "no pass line in sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f kabuki_fetch_top.f --top-module kabuki_fetch_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
